//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // plain vector types with a fixed meaning in the front end
    typedef logic [31:0]  addr_t;   // byte address
    typedef logic [31:0]  inst_t;   // one instruction word
    typedef logic [63:0]  beat_t;   // one burst beat from memory
    typedef logic [255:0] line_t;   // full cacheline

    // line geometry
    localparam int unsigned BEATS_PER_LINE = 4;
    localparam int unsigned WORDS_PER_LINE = 8;
    localparam int unsigned OFFSET_BITS    = 5;    // 32 bytes per line
    localparam int unsigned BEAT_CNT_BITS  = 2;

    // line address above the byte offset, 27 bits
    typedef logic [$bits(addr_t)-OFFSET_BITS-1:0] tag_t;

endpackage : fetch_pkg

`default_nettype wire

//--- logic/pc_gen.sv
`default_nettype none

module pc_gen
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h1eceb000
) (
    input  wire logic   clk,
    input  wire logic   rst,

    input  wire logic   hit_i,          // current pc is in the line buffer
    input  wire logic   queue_full_i,
    input  wire logic   redirect_i,
    input  wire addr_t  redirect_pc_i,

    output addr_t       pc_o,
    output logic        fetch_fire_o
);

    addr_t pc_q;

    // single enqueue decision, a redirect cycle never fetches
    always_comb begin
        fetch_fire_o = hit_i && !queue_full_i && !redirect_i;
    end

    // redirect wins over sequential advance
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (fetch_fire_o) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

endmodule : pc_gen

`default_nettype wire

//--- logic/burst_assembler.sv
`default_nettype none

module burst_assembler
    import fetch_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,

    input  wire logic   bmem_rvalid_i,
    input  wire beat_t  bmem_rdata_i,
    input  wire addr_t  bmem_raddr_i,

    output logic        line_valid_o,   // one cycle pulse per finished line
    output line_t       line_o,
    output addr_t       line_addr_o
);

    logic [BEAT_CNT_BITS-1:0] beat_cnt_q;
    logic                     line_valid_q;
    line_t                    line_q;
    addr_t                    line_addr_q;
    logic                     last_beat;

    assign last_beat = bmem_rvalid_i
                    && (beat_cnt_q == BEAT_CNT_BITS'(BEATS_PER_LINE - 1));

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q   <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= last_beat;
            if (bmem_rvalid_i) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;    // wraps after the last beat
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            // new beat enters at the top, so the first beat ends in the lowest slot
            line_q <= {bmem_rdata_i, line_q[$bits(line_t)-1:$bits(beat_t)]};
            if (beat_cnt_q == '0) begin
                line_addr_q <= bmem_raddr_i;    // address of the whole burst
            end
        end
    end

    assign line_valid_o = line_valid_q;
    assign line_o       = line_q;
    assign line_addr_o  = line_addr_q;

endmodule : burst_assembler

`default_nettype wire

//--- logic/line_buffer.sv
`default_nettype none

module line_buffer
    import fetch_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,

    input  wire addr_t  pc_i,

    // filled line from the burst assembler
    input  wire logic   line_valid_i,
    input  wire line_t  line_i,
    input  wire addr_t  line_addr_i,

    input  wire logic   bmem_ready_i,

    output logic        hit_o,
    output inst_t       inst_o,
    output logic        bmem_read_o,
    output addr_t       bmem_addr_o
);

    localparam int unsigned WORD_IDX_BITS = $clog2(WORDS_PER_LINE);

    typedef enum logic [1:0] {
        s_idle,
        s_request,
        s_wait_fill
    } lb_state_t;

    lb_state_t                state_q;
    line_t                    line_q;
    tag_t                     tag_q;
    logic                     valid_q;
    addr_t                    req_addr_q;
    tag_t                     pc_tag;
    logic [WORD_IDX_BITS-1:0] word_idx;

    assign pc_tag   = pc_i[$bits(addr_t)-1:OFFSET_BITS];
    assign word_idx = pc_i[2 +: WORD_IDX_BITS];     // skip the byte bits

    always_comb begin
        hit_o  = valid_q && (tag_q == pc_tag);
        inst_o = line_q[word_idx * $bits(inst_t) +: $bits(inst_t)];
    end

    // request held with a stable address until memory takes it
    assign bmem_read_o = (state_q == s_request);
    assign bmem_addr_o = req_addr_q;

    // refill FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= s_idle;
            valid_q <= 1'b0;
        end else begin
            unique case (state_q)
                s_idle: begin
                    if (!hit_o) begin
                        state_q <= s_request;
                    end
                end
                s_request: begin
                    if (bmem_ready_i) begin
                        state_q <= s_wait_fill;
                    end
                end
                s_wait_fill: begin
                    // install even if pc moved on, the data matches its own tag
                    if (line_valid_i) begin
                        valid_q <= 1'b1;
                        state_q <= s_idle;
                    end
                end
                default: state_q <= s_idle;
            endcase
        end
    end

    // line storage and request address
    always_ff @(posedge clk) begin
        if (state_q == s_idle && !hit_o) begin
            req_addr_q <= {pc_tag, {OFFSET_BITS{1'b0}}};   // line aligned
        end
        if (state_q == s_wait_fill && line_valid_i) begin
            line_q <= line_i;
            tag_q  <= line_addr_i[$bits(addr_t)-1:OFFSET_BITS];
        end
    end

endmodule : line_buffer

`default_nettype wire

//--- logic/inst_queue.sv
`default_nettype none

module inst_queue
    import fetch_pkg::*;
#(
    parameter int unsigned QUEUE_DEPTH = 16,   // power of two
    parameter int unsigned CREDITS     = 4
) (
    input  wire logic   clk,
    input  wire logic   rst,

    input  wire logic   flush_i,

    // write side from fetch
    input  wire logic   wr_i,
    input  wire addr_t  wr_pc_i,
    input  wire inst_t  wr_inst_i,
    output logic        full_o,

    // read side toward decode
    input  wire logic   credit_i,       // one pulse per freed decode slot
    output logic        inst_valid_o,
    output addr_t       pc_o,
    output inst_t       inst_o
);

    localparam int unsigned PTR_BITS  = $clog2(QUEUE_DEPTH);
    localparam int unsigned CNT_BITS  = PTR_BITS + 1;
    localparam int unsigned CRED_BITS = $clog2(CREDITS + 1);

    addr_t                pc_mem   [QUEUE_DEPTH];
    inst_t                inst_mem [QUEUE_DEPTH];
    logic [PTR_BITS-1:0]  wr_ptr_q;
    logic [PTR_BITS-1:0]  rd_ptr_q;
    logic [CNT_BITS-1:0]  count_q;
    logic [CRED_BITS-1:0] credit_cnt_q;
    logic                 empty;
    logic                 wr_ok;
    logic                 rd_ok;

    always_comb begin
        full_o = (count_q == CNT_BITS'(QUEUE_DEPTH));
        empty  = (count_q == '0);
        wr_ok  = wr_i && !full_o;
        // read only with a decode slot free, never in a flush cycle
        rd_ok  = !empty && (credit_cnt_q != '0) && !flush_i;
    end

    assign inst_valid_o = rd_ok;
    assign pc_o         = pc_mem[rd_ptr_q];
    assign inst_o       = inst_mem[rd_ptr_q];

    // pointers and count
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            unique case ({wr_ok, rd_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // both or neither
            endcase
        end
    end

    // decode credits survive a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt_q <= CRED_BITS'(CREDITS);
        end else begin
            unique case ({credit_i, rd_ok})
                2'b10:   credit_cnt_q <= credit_cnt_q + 1'b1;
                2'b01:   credit_cnt_q <= credit_cnt_q - 1'b1;
                default: credit_cnt_q <= credit_cnt_q;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (wr_ok && !flush_i) begin
            pc_mem[wr_ptr_q]   <= wr_pc_i;
            inst_mem[wr_ptr_q] <= wr_inst_i;
        end
    end

endmodule : inst_queue

`default_nettype wire

//--- logic/fetch_frontend.sv
`default_nettype none

module fetch_frontend
    import fetch_pkg::*;
#(
    parameter addr_t       RESET_PC    = 32'h1eceb000,
    parameter int unsigned QUEUE_DEPTH = 16,
    parameter int unsigned CREDITS     = 4
) (
    input  wire logic   clk,
    input  wire logic   rst,

    // burst memory, read only
    output addr_t       bmem_addr_o,
    output logic        bmem_read_o,
    input  wire logic   bmem_ready_i,
    input  wire addr_t  bmem_raddr_i,
    input  wire beat_t  bmem_rdata_i,
    input  wire logic   bmem_rvalid_i,

    // branch redirect
    input  wire logic   redirect_i,
    input  wire addr_t  redirect_pc_i,

    // decode, credit based
    input  wire logic   credit_i,
    output logic        inst_valid_o,
    output addr_t       pc_o,
    output inst_t       inst_o
);

    addr_t  fetch_pc;
    logic   fetch_fire;
    logic   hit;
    inst_t  fetch_inst;
    logic   queue_full;
    logic   line_valid;
    line_t  line;
    addr_t  line_addr;

    pc_gen #(
        .RESET_PC      (RESET_PC)
    ) pc_gen_i (
        .clk           (clk),
        .rst           (rst),
        .hit_i         (hit),
        .queue_full_i  (queue_full),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (fetch_pc),
        .fetch_fire_o  (fetch_fire)
    );

    burst_assembler burst_assembler_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .line_valid_o  (line_valid),
        .line_o        (line),
        .line_addr_o   (line_addr)
    );

    line_buffer line_buffer_i (
        .clk           (clk),
        .rst           (rst),
        .pc_i          (fetch_pc),
        .line_valid_i  (line_valid),
        .line_i        (line),
        .line_addr_i   (line_addr),
        .bmem_ready_i  (bmem_ready_i),
        .hit_o         (hit),
        .inst_o        (fetch_inst),
        .bmem_read_o   (bmem_read_o),
        .bmem_addr_o   (bmem_addr_o)
    );

    // redirect doubles as the queue flush
    inst_queue #(
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .CREDITS       (CREDITS)
    ) inst_queue_i (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (redirect_i),
        .wr_i          (fetch_fire),
        .wr_pc_i       (fetch_pc),
        .wr_inst_i     (fetch_inst),
        .full_o        (queue_full),
        .credit_i      (credit_i),
        .inst_valid_o  (inst_valid_o),
        .pc_o          (pc_o),
        .inst_o        (inst_o)
    );

endmodule : fetch_frontend

`default_nettype wire

//--- testbench/fetch_frontend_props.sv
`default_nettype none

module fetch_frontend_props
    import fetch_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   bmem_read_i,
    input  wire addr_t  bmem_addr_i,
    input  wire logic   bmem_ready_i,
    input  wire logic   redirect_i,
    input  wire logic   inst_valid_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // refills always ask for a whole line
    line_aligned_a: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> (bmem_addr_i[OFFSET_BITS-1:0] == '0))
        else $error("refill address %h is not line aligned", bmem_addr_i);

    // request waits with a fixed address until memory takes it
    request_stable_a: assert property (@(posedge clk) disable iff (rst)
        (bmem_read_i && !bmem_ready_i) |=> (bmem_read_i && $stable(bmem_addr_i)))
        else $error("refill request dropped or changed before ready");

    no_output_blocked_a: assert property (@(posedge clk)
        (rst || redirect_i) |-> (inst_valid_i !== 1'b1))
        else $error("instruction output during reset or redirect");

endmodule : fetch_frontend_props

bind fetch_frontend fetch_frontend_props props_i (
    .clk          (clk),
    .rst          (rst),
    .bmem_read_i  (bmem_read_o),
    .bmem_addr_i  (bmem_addr_o),
    .bmem_ready_i (bmem_ready_i),
    .redirect_i   (redirect_i),
    .inst_valid_i (inst_valid_o)
);

`default_nettype wire

//--- testbench/fetch_frontend_tb.sv
`default_nettype none

module fetch_frontend_tb
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t RESET_PC  = 32'h1eceb000;
    localparam int    CREDITS   = 4;
    localparam int    TIMEOUT   = 3000;    // cycles allowed per wait
    localparam int    NUM_TESTS = 6;

    // test table with one column per field
    string t_name   [NUM_TESTS] = '{"reset_seq", "credit_hold", "redirect", "refill_redirect",
                                    "mem_stall", "stall_refill_redirect"};
    bit    t_reset  [NUM_TESTS] = '{1, 0, 0, 0, 0, 0};
    addr_t t_pc     [NUM_TESTS] = '{RESET_PC, 32'h0000_2000, 32'h0000_4104, 32'h0000_6010,
                                    32'h0003_0008, 32'h0000_a01c};
    addr_t t_refill [NUM_TESTS] = '{32'h0, 32'h0, 32'h0, 32'h0000_8000,
                                    32'h0, 32'h0000_c000};     // 0 means no refill detour
    int    t_count  [NUM_TESTS] = '{16, 12, 10, 12, 24, 20};
    bit    t_hold   [NUM_TESTS] = '{0, 1, 0, 0, 0, 0};
    bit    t_stall  [NUM_TESTS] = '{0, 0, 0, 0, 1, 1};

    logic  clk;
    logic  rst;
    addr_t bmem_addr_o;
    logic  bmem_read_o;
    logic  bmem_ready_i;
    addr_t bmem_raddr_i;
    beat_t bmem_rdata_i;
    logic  bmem_rvalid_i;
    logic  redirect_i;
    addr_t redirect_pc_i;
    logic  credit_i;
    logic  inst_valid_o;
    addr_t pc_o;
    inst_t inst_o;

    addr_t got_pc[$];       // what decode received
    inst_t got_inst[$];
    addr_t accepted[$];     // addresses of accepted refills
    bit    hold_credits;
    bit    stall_mode;
    int    pass_cnt;
    int    fail_cnt;

    fetch_frontend UUT (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory contents are the address xor a pattern plus the word index in the line
    function automatic inst_t mem_word(input addr_t a);
        return (a ^ 32'h5a5a_0000) + 32'(a[4:2]);
    endfunction

    function automatic beat_t beat_data(input addr_t line_addr, input int b);
        addr_t lo;
        lo = line_addr + addr_t'(8 * b);
        return {mem_word(lo + 32'd4), mem_word(lo)};   // lower word in the low half
    endfunction

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin : memory_model
        logic [31:0] seed;
        int          stall_left;
        int          b;
        addr_t       req;
        seed          = 32'd2352;
        stall_left    = 0;
        bmem_ready_i  = 1'b0;
        bmem_rvalid_i = 1'b0;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        forever begin
            @(negedge clk);
            bmem_rvalid_i = 1'b0;
            if (stall_mode && stall_left == 0) begin
                seed       = lcg_next(seed);
                stall_left = int'(seed[20:18]);
            end
            if (stall_left > 0) begin
                bmem_ready_i = 1'b0;
                stall_left--;
            end else begin
                bmem_ready_i = 1'b1;
            end
            if (bmem_read_o === 1'b1 && bmem_ready_i) begin
                req = bmem_addr_o;
                @(posedge clk);
                accepted.push_back(req);    // taken on this edge
                @(negedge clk);
                bmem_ready_i = 1'b0;        // one burst at a time
                @(negedge clk);
                for (b = 0; b < BEATS_PER_LINE; b++) begin
                    bmem_rvalid_i = 1'b1;
                    bmem_raddr_i  = req;
                    bmem_rdata_i  = beat_data(req, b);
                    @(negedge clk);
                    bmem_rvalid_i = 1'b0;
                    seed = lcg_next(seed);
                    if (stall_mode && seed[16]) begin
                        @(negedge clk);     // gap between beats
                    end
                end
            end
        end
    end

    initial begin : decode_model
        logic [31:0] seed;
        int          new_items;
        int          owed;
        int          withheld;
        int          gap;
        seed     = 32'd2352;
        owed     = 0;
        withheld = 0;
        gap      = 0;
        credit_i = 1'b0;
        forever begin
            @(posedge clk);
            new_items = 0;
            if (inst_valid_o === 1'b1) begin
                got_pc.push_back(pc_o);
                got_inst.push_back(inst_o);
                new_items = 1;
            end
            @(negedge clk);
            if (hold_credits) begin
                withheld += new_items;
            end else begin
                owed     += new_items + withheld;
                withheld  = 0;
            end
            credit_i = 1'b0;
            if (owed > 0 && gap == 0) begin
                credit_i = 1'b1;
                owed--;
                seed = lcg_next(seed);
                gap  = int'(seed[18:17]);   // up to 3 idle cycles per credit
            end else if (gap > 0) begin
                gap--;
            end
        end
    end

    task automatic redirect_to(input addr_t target, input bit hold);
        @(negedge clk);
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        got_pc.delete();
        got_inst.delete();
        @(posedge clk);
        hold_credits = hold;    // queue cannot deliver in this cycle
        @(negedge clk);
        redirect_i = 1'b0;
    endtask

    task automatic wait_refill(input addr_t line_addr, output bit ok);
        int cycles;
        cycles = 0;
        while ((accepted.size() == 0 || accepted[$] != line_addr) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (accepted.size() != 0 && accepted[$] == line_addr);
    endtask

    task automatic wait_outputs(input int n, output bit ok);
        int cycles;
        cycles = 0;
        while (got_pc.size() < n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (got_pc.size() >= n);
    endtask

    task automatic start_test(input int t, output bit ok);
        ok = 1'b1;
        @(posedge clk);
        stall_mode = t_stall[t];
        if (t_reset[t]) begin
            @(negedge clk);
            rst = 1'b1;
            got_pc.delete();
            got_inst.delete();
            accepted.delete();
            @(posedge clk);
            hold_credits = t_hold[t];
            repeat (4) @(negedge clk);
            rst = 1'b0;
        end else begin
            if (t_refill[t] != 32'h0) begin
                // second redirect lands while this refill is in flight
                redirect_to(t_refill[t], 1'b0);
                wait_refill({t_refill[t][31:OFFSET_BITS], 5'b0}, ok);
            end
            redirect_to(t_pc[t], t_hold[t]);
        end
    endtask

    task automatic run_test(input int t);
        int    errors;
        int    i;
        int    in_range;
        bit    ok;
        addr_t exp_pc;
        errors = 0;
        start_test(t, ok);
        if (!ok) begin
            $display("%s: refill request never accepted", t_name[t]);
            errors++;
        end
        if (t_hold[t]) begin
            wait_outputs(CREDITS, ok);
            if (!ok) begin
                $display("%s: timed out with %0d of %0d instructions received on held credits",
                         t_name[t], got_pc.size(), CREDITS);
                errors++;
            end else begin
                repeat (25) @(negedge clk);     // nothing more may arrive without credits
                if (got_pc.size() != CREDITS) begin
                    $display("mismatch %s outputs: expected %0d, actual %0d",
                             t_name[t], CREDITS, got_pc.size());
                    errors++;
                end
            end
            @(posedge clk);
            hold_credits = 1'b0;
        end
        wait_outputs(t_count[t], ok);
        if (!ok) begin
            $display("%s: timed out with %0d of %0d instructions received",
                     t_name[t], got_pc.size(), t_count[t]);
            errors++;
        end else begin
            for (i = 0; i < t_count[t]; i++) begin
                exp_pc = t_pc[t] + 32'(4 * i);
                if (got_pc[i] !== exp_pc) begin
                    $display("mismatch %s pc[%0d]: expected %h, actual %h",
                             t_name[t], i, exp_pc, got_pc[i]);
                    errors++;
                    break;
                end
                if (got_inst[i] !== mem_word(exp_pc)) begin
                    $display("mismatch %s inst[%0d]: expected %h, actual %h",
                             t_name[t], i, mem_word(exp_pc), got_inst[i]);
                    errors++;
                    break;
                end
            end
        end
        if (t_reset[t]) begin
            in_range = 0;
            foreach (accepted[k]) begin
                if (accepted[k] - t_pc[t] < 32'd64) in_range++;    // first two lines only
            end
            if (in_range != 2) begin
                $display("mismatch %s line reads: expected 2, actual %0d", t_name[t], in_range);
                errors++;
            end else if (accepted[0] !== t_pc[t] || accepted[1] !== t_pc[t] + 32'd32) begin
                $display("mismatch %s read addresses: expected %h %h, actual %h %h",
                         t_name[t], t_pc[t], t_pc[t] + 32'd32, accepted[0], accepted[1]);
                errors++;
            end
        end
        if (errors == 0) pass_cnt++;
        else fail_cnt++;
        $display("test %s: %s", t_name[t], (errors == 0) ? "pass" : "fail");
    endtask

    initial begin : main
        int t;
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        hold_credits  = 1'b0;
        stall_mode    = 1'b0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : fetch_frontend_tb

`default_nettype wire

//--- project.f
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/burst_assembler.sv
logic/line_buffer.sv
logic/inst_queue.sv
logic/fetch_frontend.sv
testbench/fetch_frontend_props.sv
testbench/fetch_frontend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the fetch front end testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module fetch_frontend_tb -f project.f &&
    ./obj_dir/Vfetch_frontend_tb | tee /dev/stderr |
    grep -F "Simulation completed successfully" > /dev/null &&
    exit 0 || exit 1
